//--- rv32_pkg.sv
// Shared RV32I types and constants for the two-stage core.
// Only the opcodes of the supported subset are listed; all others trap.
`default_nettype none

package rv32_pkg;

  // Widths with a meaning of their own.
  typedef logic [31:0] word_t;    // Data or instruction word.
  typedef logic [31:0] addr_t;    // Byte address.
  typedef logic [4:0]  reg_idx_t; // Register index x0..x31.

  // Major opcodes, bits [6:0] of the instruction.
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011, // ADD, SUB.
    op_imm    = 7'b0010011, // ADDI.
    op_load   = 7'b0000011, // LW.
    op_store  = 7'b0100011, // SW.
    op_branch = 7'b1100011, // BEQ, BNE.
    op_jal    = 7'b1101111, // JAL.
    op_system = 7'b1110011  // EBREAK only.
  } opcode_t;

  // ALU operations.
  typedef enum logic {
    alu_add = 1'b0,
    alu_sub = 1'b1
  } alu_op_t;

  // First fetch address after reset.
  localparam addr_t RESET_PC = 32'h0000_0000;

  // Fetch address taken on an illegal instruction.
  localparam addr_t TRAP_VECTOR = 32'h0000_0200;

  // ADDI x0, x0, 0.
  // The IF/EX latch holds this after reset and after a flush.
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

//--- register_file.sv
// 32 x 32-bit register file, synchronous write, asynchronous read.
// x0 reads zero and ignores writes.
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire rv32_pkg::reg_idx_t rs1_idx,
  input  wire rv32_pkg::reg_idx_t rs2_idx,
  input  wire logic               wr_en,
  input  wire rv32_pkg::reg_idx_t wr_idx,
  input  wire rv32_pkg::word_t    wr_data,
  output rv32_pkg::word_t         rs1_data,
  output rv32_pkg::word_t         rs2_data
);

  rv32_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != 5'd0)) begin
      regs[wr_idx] <= wr_data; // x0 stays zero.
    end
  end

  // Read ports, no bypass of the write in the same cycle.
  assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

//--- fetch_stage.sv
// Fetch stage: PC register, instruction port and the IF/EX latch.
// irdata is sampled only when the latch is neither stalled nor flushed.
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            pc_en,         // PC may move this cycle.
  input  wire logic            npc_sel,       // Take branch_target.
  input  wire logic            insert_pc,     // Take redirect_pc, wins over npc_sel.
  input  wire logic            if_ex_stall,   // Hold the latch.
  input  wire logic            if_ex_flush,   // Load a NOP, wins over stall.
  input  wire rv32_pkg::addr_t branch_target,
  input  wire rv32_pkg::addr_t redirect_pc,
  input  wire rv32_pkg::word_t irdata,
  input  wire logic            halted,
  output logic                 iren,
  output rv32_pkg::addr_t      iaddr,
  output rv32_pkg::addr_t      if_pc,
  output rv32_pkg::word_t      if_instr
);

  rv32_pkg::addr_t pc;      // Address being fetched.
  rv32_pkg::addr_t next_pc;

  // Next PC selection.
  always_comb begin
    if (insert_pc) begin
      next_pc = redirect_pc;  // Trap redirect.
    end else if (npc_sel) begin
      next_pc = branch_target; // Taken branch or JAL.
    end else begin
      next_pc = pc + 32'd4;   // Sequential.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= rv32_pkg::RESET_PC;
    end else if (pc_en) begin
      pc <= next_pc;
    end
  end

  // IF/EX latch.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_instr <= rv32_pkg::NOP_INSTR;
      if_pc    <= rv32_pkg::RESET_PC;
    end else if (if_ex_flush) begin
      if_instr <= rv32_pkg::NOP_INSTR; // Squash wrong path or trapped slot.
      if_pc    <= pc;
    end else if (!if_ex_stall) begin
      if_instr <= irdata;
      if_pc    <= pc;
    end
  end

  assign iaddr = pc;
  assign iren  = ~halted; // No fetch once halted.

endmodule

`default_nettype wire

//--- hazard_unit.sv
// Stall, flush and PC control for the two-stage pipeline.
// Purely combinational; an exception in EX overrides every stall.
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  wire logic branch,      // Branch in EX.
  input  wire logic mispredict,  // Its condition holds.
  input  wire logic jump,        // JAL in EX.
  input  wire logic dren,
  input  wire logic dwen,
  input  wire logic iren,
  input  wire logic i_ram_busy,
  input  wire logic d_ram_busy,
  input  wire logic halt,        // EBREAK in EX or core halted.
  input  wire logic ex_excptn,   // Illegal instruction in EX.
  output logic      pc_en,
  output logic      npc_sel,
  output logic      insert_pc,
  output logic      if_ex_stall,
  output logic      if_ex_flush,
  output logic      ex_advance
);

  logic dmem_access;   // EX uses the data port.
  logic branch_jump;   // Redirect to branch or JAL target.
  logic wait_for_imem; // Fetch not yet returned.
  logic wait_for_dmem; // Load or store not yet done.

  assign dmem_access   = dren | dwen;
  assign branch_jump   = jump | (branch & mispredict); // Predict not taken.
  assign wait_for_imem = iren & i_ram_busy;
  assign wait_for_dmem = dmem_access & d_ram_busy;

  assign npc_sel   = branch_jump;
  assign insert_pc = ex_excptn; // Trap vector.

  // PC moves when the fetch returned, or on any redirect.
  assign pc_en = (~wait_for_dmem & ~wait_for_imem & ~halt) | branch_jump | ex_excptn;

  // A finished memory op under a busy fetch leaves a NOP behind,
  // so the access is never issued twice.
  assign if_ex_flush = ex_excptn | branch_jump |
                       (wait_for_imem & dmem_access & ~d_ram_busy);

  // Hold EX while data waits, while fetch waits with nothing to retire, or when halted.
  assign if_ex_stall = (wait_for_dmem | (wait_for_imem & ~dmem_access & ~branch_jump) |
                        halt) & ~ex_excptn;

  // EX instruction retires in the cycle it leaves the latch.
  assign ex_advance = ~if_ex_stall;

endmodule

`default_nettype wire

//--- execute_stage.sv
// Execute stage: decode, ALU, branches, data port, writeback and halt.
// Only the opcode is checked for legality; funct fields are partly decoded.
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire rv32_pkg::addr_t    if_pc,
  input  wire rv32_pkg::word_t    if_instr,
  input  wire logic               ex_advance,  // Instruction retires this cycle.
  input  wire rv32_pkg::word_t    rs1_data,
  input  wire rv32_pkg::word_t    rs2_data,
  input  wire rv32_pkg::word_t    drdata,
  output rv32_pkg::reg_idx_t      rs1_idx,
  output rv32_pkg::reg_idx_t      rs2_idx,
  output logic                    wr_en,
  output rv32_pkg::reg_idx_t      wr_idx,
  output rv32_pkg::word_t         wr_data,
  output logic                    branch,
  output logic                    mispredict,
  output logic                    jump,
  output logic                    ex_excptn,
  output logic                    halt,
  output rv32_pkg::addr_t         branch_target,
  output rv32_pkg::addr_t         redirect_pc,
  output logic                    dren,
  output logic                    dwen,
  output rv32_pkg::addr_t         daddr,
  output rv32_pkg::word_t         dwdata,
  output logic                    halted
);

  rv32_pkg::opcode_t opcode;
  rv32_pkg::alu_op_t alu_op;
  rv32_pkg::word_t   imm_i;
  rv32_pkg::word_t   imm_s;
  rv32_pkg::word_t   imm_b;
  rv32_pkg::word_t   imm_j;
  rv32_pkg::word_t   imm;        // Selected ALU immediate.
  rv32_pkg::word_t   operand_b;
  rv32_pkg::word_t   alu_result;
  rv32_pkg::addr_t   link_addr;  // pc + 4 for JAL.
  logic              use_imm;
  logic              writes_rd;
  logic              is_load;
  logic              is_store;
  logic              is_branch;
  logic              is_jal;
  logic              is_ebreak;
  logic              illegal;

  assign opcode = rv32_pkg::opcode_t'(if_instr[6:0]);

  // Immediate formats.
  assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
  assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
  assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                  if_instr[30:25], if_instr[11:8], 1'b0};
  assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                  if_instr[20], if_instr[30:21], 1'b0};

  // Control decode.
  always_comb begin
    alu_op    = rv32_pkg::alu_add;
    imm       = imm_i;
    use_imm   = 1'b0;
    writes_rd = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_ebreak = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      rv32_pkg::op_reg: begin
        writes_rd = 1'b1;
        alu_op    = if_instr[30] ? rv32_pkg::alu_sub : rv32_pkg::alu_add; // funct7 bit 5.
      end
      rv32_pkg::op_imm: begin
        writes_rd = 1'b1;
        use_imm   = 1'b1;
      end
      rv32_pkg::op_load: begin
        writes_rd = 1'b1;
        is_load   = 1'b1;
        use_imm   = 1'b1;
      end
      rv32_pkg::op_store: begin
        is_store = 1'b1;
        use_imm  = 1'b1;
        imm      = imm_s;
      end
      rv32_pkg::op_branch: is_branch = 1'b1;
      rv32_pkg::op_jal: begin
        writes_rd = 1'b1;
        is_jal    = 1'b1;
      end
      rv32_pkg::op_system: begin
        // EBREAK has funct12 = 1 and all other fields zero.
        if ((if_instr[31:20] == 12'h001) && (if_instr[19:7] == 13'd0)) begin
          is_ebreak = 1'b1;
        end else begin
          illegal = 1'b1; // ECALL and CSR ops are not supported.
        end
      end
      default: illegal = 1'b1;
    endcase
  end

  // ALU, also the load/store address.
  assign operand_b  = use_imm ? imm : rs2_data;
  assign alu_result = (alu_op == rv32_pkg::alu_sub) ? (rs1_data - operand_b)
                                                    : (rs1_data + operand_b);

  // Branch resolution. funct3[0] turns BEQ into BNE.
  assign branch        = is_branch;
  assign mispredict    = (rs1_data == rs2_data) ^ if_instr[12];
  assign jump          = is_jal;
  assign link_addr     = if_pc + 32'd4;
  assign branch_target = is_jal ? (if_pc + imm_j) : (if_pc + imm_b);
  assign redirect_pc   = rv32_pkg::TRAP_VECTOR;
  assign ex_excptn     = illegal;

  // Data port, held while the instruction waits in EX.
  assign dren   = is_load;
  assign dwen   = is_store;
  assign daddr  = alu_result;
  assign dwdata = rs2_data;

  // Register file access.
  assign rs1_idx = if_instr[19:15];
  assign rs2_idx = if_instr[24:20];
  assign wr_idx  = if_instr[11:7];
  assign wr_en   = writes_rd & ex_advance; // Once per instruction.

  always_comb begin
    if (is_load) begin
      wr_data = drdata;     // Valid when d_ram_busy drops.
    end else if (is_jal) begin
      wr_data = link_addr;
    end else begin
      wr_data = alu_result;
    end
  end

  // Halt flag. Sticky until reset.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (is_ebreak) begin
      halted <= 1'b1;
    end
  end

  assign halt = is_ebreak | halted; // Freeze from the EBREAK cycle on.

endmodule

`default_nettype wire

//--- two_stage_core.sv
// Two-stage RV32I subset core with external instruction and data memories.
// Memories signal back-pressure by busy levels only; there is no handshake.
`timescale 1ns/1ps
`default_nettype none

module two_stage_core (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire rv32_pkg::word_t irdata,
  input  wire logic            i_ram_busy,
  input  wire rv32_pkg::word_t drdata,
  input  wire logic            d_ram_busy,
  output logic                 iren,
  output rv32_pkg::addr_t      iaddr,
  output logic                 dren,
  output logic                 dwen,
  output rv32_pkg::addr_t      daddr,
  output rv32_pkg::word_t      dwdata,
  output logic                 halted
);

  // IF/EX latch contents.
  rv32_pkg::addr_t    if_pc;
  rv32_pkg::word_t    if_instr;

  // Hazard controls.
  logic               pc_en;
  logic               npc_sel;
  logic               insert_pc;
  logic               if_ex_stall;
  logic               if_ex_flush;
  logic               ex_advance;

  // Execute status toward the hazard unit and fetch.
  logic               branch;
  logic               mispredict;
  logic               jump;
  logic               ex_excptn;
  logic               halt;
  rv32_pkg::addr_t    branch_target;
  rv32_pkg::addr_t    redirect_pc;

  // Register file ports.
  rv32_pkg::reg_idx_t rs1_idx;
  rv32_pkg::reg_idx_t rs2_idx;
  rv32_pkg::word_t    rs1_data;
  rv32_pkg::word_t    rs2_data;
  logic               wr_en;
  rv32_pkg::reg_idx_t wr_idx;
  rv32_pkg::word_t    wr_data;

  fetch_stage fetch_stage_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_en         (pc_en),
    .npc_sel       (npc_sel),
    .insert_pc     (insert_pc),
    .if_ex_stall   (if_ex_stall),
    .if_ex_flush   (if_ex_flush),
    .branch_target (branch_target),
    .redirect_pc   (redirect_pc),
    .irdata        (irdata),
    .halted        (halted),
    .iren          (iren),
    .iaddr         (iaddr),
    .if_pc         (if_pc),
    .if_instr      (if_instr)
  );

  hazard_unit hazard_unit_i (
    .branch      (branch),
    .mispredict  (mispredict),
    .jump        (jump),
    .dren        (dren),
    .dwen        (dwen),
    .iren        (iren),
    .i_ram_busy  (i_ram_busy),
    .d_ram_busy  (d_ram_busy),
    .halt        (halt),
    .ex_excptn   (ex_excptn),
    .pc_en       (pc_en),
    .npc_sel     (npc_sel),
    .insert_pc   (insert_pc),
    .if_ex_stall (if_ex_stall),
    .if_ex_flush (if_ex_flush),
    .ex_advance  (ex_advance)
  );

  execute_stage execute_stage_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_pc         (if_pc),
    .if_instr      (if_instr),
    .ex_advance    (ex_advance),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .drdata        (drdata),
    .rs1_idx       (rs1_idx),
    .rs2_idx       (rs2_idx),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_data       (wr_data),
    .branch        (branch),
    .mispredict    (mispredict),
    .jump          (jump),
    .ex_excptn     (ex_excptn),
    .halt          (halt),
    .branch_target (branch_target),
    .redirect_pc   (redirect_pc),
    .dren          (dren),
    .dwen          (dwen),
    .daddr         (daddr),
    .dwdata        (dwdata),
    .halted        (halted)
  );

  register_file register_file_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_data  (wr_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

endmodule

`default_nettype wire

//--- core_tb.sv
// Testbench for two_stage_core with random programs, busy memories and an ISA model.
// Programs use x0..x15 and branch forward only; seed 22 fixes every run.
`timescale 1ns/1ps
`default_nettype none

module core_tb;

  localparam int BODY_LEN   = 40;    // Random body, words 0..39.
  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 128;
  localparam int DUMP_BASE  = 'h100; // Dump of x1..x15 in dmem words 65..79.
  localparam int TIMEOUT    = 4000;  // Cycles allowed per program.
  localparam int K_BRANCH   = 1;
  localparam int K_MEM      = 2;
  localparam int K_ILLEGAL  = 4;
  localparam rv32_pkg::word_t MARKER = 32'hBAD0_0BAD;

  logic            clk;
  logic            rst_n;
  rv32_pkg::word_t irdata;
  logic            i_ram_busy;
  rv32_pkg::word_t drdata;
  logic            d_ram_busy;
  logic            iren;
  rv32_pkg::addr_t iaddr;
  logic            dren;
  logic            dwen;
  rv32_pkg::addr_t daddr;
  rv32_pkg::word_t dwdata;
  logic            halted;

  integer          seed = 22;
  int              i_busy_pct;     // Chance of a busy imem cycle.
  int              d_busy_pct;
  rv32_pkg::word_t imem [IMEM_WORDS];
  rv32_pkg::word_t dmem [DMEM_WORDS];
  rv32_pkg::word_t mdl_mem [DMEM_WORDS]; // Model copy of dmem.
  rv32_pkg::word_t mdl_regs [32];
  rv32_pkg::addr_t exp_addr [$];         // Expected stores in order.
  rv32_pkg::word_t exp_data [$];
  rv32_pkg::addr_t exp_load_addr [$];    // Expected loads in order.
  rv32_pkg::word_t exp_load_data [$];
  rv32_pkg::addr_t halt_pc;              // PC of the final EBREAK.

  two_stage_core two_stage_core_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .irdata     (irdata),
    .i_ram_busy (i_ram_busy),
    .drdata     (drdata),
    .d_ram_busy (d_ram_busy),
    .iren       (iren),
    .iaddr      (iaddr),
    .dren       (dren),
    .dwen       (dwen),
    .daddr      (daddr),
    .dwdata     (dwdata),
    .halted     (halted)
  );

  always #50 clk = ~clk; // 100 ns period.

  function automatic int pick(input int n);
    pick = ($random(seed) & 32'h7fff_ffff) % n; // Uniform 0..n-1.
  endfunction

  // RV32I instruction encoders.
  function automatic rv32_pkg::word_t r_type(input logic sub, input rv32_pkg::reg_idx_t rd,
                                             input rv32_pkg::reg_idx_t rs1,
                                             input rv32_pkg::reg_idx_t rs2);
    r_type = {1'b0, sub, 5'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic rv32_pkg::word_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                             input rv32_pkg::reg_idx_t rd,
                                             input logic [11:0] imm);
    i_type = {imm, 5'd0, f3, rd, op}; // Base is always x0.
  endfunction

  function automatic rv32_pkg::word_t s_type(input rv32_pkg::reg_idx_t rs2,
                                             input logic [11:0] imm);
    s_type = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv32_pkg::word_t b_type(input logic [2:0] f3,
                                             input rv32_pkg::reg_idx_t rs1,
                                             input rv32_pkg::reg_idx_t rs2,
                                             input logic [12:0] off);
    b_type = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic rv32_pkg::word_t j_type(input rv32_pkg::reg_idx_t rd,
                                             input logic [20:0] off);
    j_type = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic rv32_pkg::word_t fill_word(input int w);
    fill_word = (32'h5A00_0000 ^ (w * 32'h0001_0203)) + w; // Every address differs.
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_store(input rv32_pkg::addr_t got_a, input rv32_pkg::word_t got_d,
                             input rv32_pkg::addr_t exp_a, input rv32_pkg::word_t exp_d);
    if ((got_a !== exp_a) || (got_d !== exp_d)) begin
      report_mismatch($sformatf("store %h <= %h, expected %h <= %h",
                                got_a, got_d, exp_a, exp_d));
    end
  endtask

  task automatic check_load_data(input rv32_pkg::addr_t got_a, input rv32_pkg::word_t got_d,
                                 input rv32_pkg::addr_t exp_a, input rv32_pkg::word_t exp_d);
    if ((got_a !== exp_a) || (got_d !== exp_d)) begin
      report_mismatch($sformatf("load %h => %h, expected %h => %h",
                                got_a, got_d, exp_a, exp_d));
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch($sformatf("halted is %b, expected %b", got, exp));
    end
  endtask

  task automatic check_fetch_addr(input rv32_pkg::addr_t got, input rv32_pkg::addr_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("iaddr is %h, expected %h", got, exp));
    end
  endtask

  // Memories answer at the falling edge and accesses commit at the next rising edge.
  task automatic clock_cycle();
    @(negedge clk);
    i_ram_busy = (pick(100) < i_busy_pct);
    d_ram_busy = (pick(100) < d_busy_pct);
    irdata     = imem[iaddr[9:2]];
    drdata     = dmem[daddr[8:2]];
    if (rst_n && dren && !d_ram_busy) begin // Load completes this cycle.
      if (exp_load_addr.size() == 0) begin
        report_error("the core read memory after the last expected load");
      end
      check_load_data(daddr, drdata, exp_load_addr.pop_front(), exp_load_data.pop_front());
    end
    if (rst_n && dwen && !d_ram_busy) begin // Store completes this cycle.
      if (exp_addr.size() == 0) begin
        report_error("the core wrote memory after the last expected store");
      end
      check_store(daddr, dwdata, exp_addr.pop_front(), exp_data.pop_front());
      dmem[daddr[8:2]] = dwdata;
    end
  endtask

  task automatic build_program(input int kind);
    int              ill_at;
    int              c;
    int              t;
    rv32_pkg::word_t ins;
    for (int i = 0; i < IMEM_WORDS; i++) imem[i] = rv32_pkg::NOP_INSTR;
    ill_at = (kind & K_ILLEGAL) ? 5 + pick(BODY_LEN - 10) : -1;
    for (int i = 0; i < BODY_LEN; i++) begin
      c = pick(10);
      if (i == ill_at) begin
        ins      = $random(seed);
        ins[6:0] = 7'b0001011; // Custom-0 is outside the subset.
      end else if (c < 4) begin
        ins = r_type(1'(pick(2)), 5'(pick(16)), 5'(pick(16)), 5'(pick(16)));
      end else if (c < 6 || (c < 8 && !(kind & K_MEM)) || (c >= 8 && !(kind & K_BRANCH))) begin
        ins = i_type(7'b0010011, 3'b000, 5'(pick(16)), 12'(pick(4096))); // ADDI from x0.
      end else if (c < 8) begin
        if (pick(2) == 1) ins = i_type(7'b0000011, 3'b010, 5'(pick(16)), 12'(pick(32) * 4));
        else ins = s_type(5'(pick(16)), 12'(pick(32) * 4));
      end else begin
        t = i + 2 + pick(4); // Forward target inside the body or at the tail.
        if (t > BODY_LEN) t = BODY_LEN;
        if (c == 8) ins = b_type(3'(pick(2)), 5'(pick(16)), 5'(pick(16)), 13'((t - i) * 4));
        else ins = j_type(5'(pick(16)), 21'((t - i) * 4));
      end
      imem[i] = ins;
    end
    for (int k = 1; k < 16; k++) begin
      imem[BODY_LEN + k - 1] = s_type(5'(k), 12'(DUMP_BASE + 4 * k)); // Dump x1..x15.
    end
    imem[BODY_LEN + 15] = 32'h0010_0073; // EBREAK.
    // Trap handler writes the marker from dmem word 127.
    imem[rv32_pkg::TRAP_VECTOR[9:2]]     = i_type(7'b0000011, 3'b010, 5'd1, 12'h1FC);
    imem[rv32_pkg::TRAP_VECTOR[9:2] + 1] = s_type(5'd1, 12'h180);
    imem[rv32_pkg::TRAP_VECTOR[9:2] + 2] = 32'h0010_0073;
    for (int w = 0; w < DMEM_WORDS; w++) dmem[w] = fill_word(w);
    dmem[127] = MARKER;
  endtask

  // ISA model without timing. Fills the expected store and load lists.
  task automatic run_model();
    rv32_pkg::addr_t pc;
    rv32_pkg::addr_t a;
    rv32_pkg::word_t ins;
    rv32_pkg::word_t val;
    rv32_pkg::word_t rs1v;
    rv32_pkg::word_t rs2v;
    logic            wr;
    logic            done;
    int              steps;
    pc    = rv32_pkg::RESET_PC;
    done  = 1'b0;
    steps = 0;
    for (int r = 0; r < 32; r++) mdl_regs[r] = '0;
    for (int w = 0; w < DMEM_WORDS; w++) mdl_mem[w] = dmem[w];
    while (!done) begin
      ins  = imem[pc[9:2]];
      rs1v = mdl_regs[ins[19:15]];
      rs2v = mdl_regs[ins[24:20]];
      wr   = 1'b1;
      val  = '0;
      case (ins[6:0])
        7'b0110011: val = ins[30] ? rs1v - rs2v : rs1v + rs2v;
        7'b0010011: val = rs1v + {{20{ins[31]}}, ins[31:20]};
        7'b0000011: begin
          a   = rs1v + {{20{ins[31]}}, ins[31:20]};
          val = mdl_mem[a[8:2]];
          exp_load_addr.push_back(a);
          exp_load_data.push_back(val);
        end
        7'b0100011: begin
          wr = 1'b0;
          a  = rs1v + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          exp_addr.push_back(a);
          exp_data.push_back(rs2v);
          mdl_mem[a[8:2]] = rs2v;
        end
        7'b1100011: wr = 1'b0;
        7'b1101111: val = pc + 32'd4; // Link.
        7'b1110011: begin
          wr      = 1'b0;
          done    = 1'b1; // EBREAK.
          halt_pc = pc;
        end
        default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0) mdl_regs[ins[11:7]] = val;
      if (ins[6:0] == 7'b1101111) begin
        pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end else if (ins[6:0] == 7'b1100011 &&
                   ((ins[14:12] == 3'b000) ? (rs1v == rs2v) : (rs1v != rs2v))) begin
        pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end else if (ins[6:0] == 7'b0110011 || ins[6:0] == 7'b0010011 ||
                   ins[6:0] == 7'b0000011 || ins[6:0] == 7'b0100011 ||
                   ins[6:0] == 7'b1100011 || ins[6:0] == 7'b1110011) begin
        pc = pc + 32'd4;
      end else begin
        pc = rv32_pkg::TRAP_VECTOR; // Illegal opcode.
      end
      steps++;
      if (steps > 1000) report_error("the ISA model did not reach EBREAK");
    end
  endtask

  task automatic run_test(input int kind, input int ipct, input int dpct);
    int cycles;
    rst_n      = 1'b0;
    i_busy_pct = ipct;
    d_busy_pct = dpct;
    exp_addr.delete();
    exp_data.delete();
    exp_load_addr.delete();
    exp_load_data.delete();
    build_program(kind);
    run_model();
    repeat (5) clock_cycle(); // Reset for 5 cycles.
    rst_n  = 1'b1;
    cycles = 0;
    while (exp_addr.size() != 0) begin // Halted stays low up to the last store.
      clock_cycle();
      check_halt(halted, 1'b0);
      cycles++;
      if (cycles > TIMEOUT) report_error("timeout waiting for the expected stores");
    end
    while (halted !== 1'b1) begin
      clock_cycle();
      cycles++;
      if (cycles > TIMEOUT) report_error("timeout waiting for the core to halt");
    end
    if (exp_load_addr.size() != 0) report_error("the core halted before all expected loads");
    for (int n = 0; n < 20; n++) begin // Frozen after EBREAK.
      clock_cycle();
      check_halt(halted, 1'b1);
      check_fetch_addr(iaddr, halt_pc + 32'd4);
      if (iren !== 1'b0) report_error("instruction fetch after halt");
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    irdata     = rv32_pkg::NOP_INSTR;
    drdata     = '0;
    i_ram_busy = 1'b0;
    d_ram_busy = 1'b0;
    i_busy_pct = 0;
    d_busy_pct = 0;
    run_test(0, 0, 0);                     // ALU only with idle memories.
    run_test(K_BRANCH, 0, 0);              // Branches and JAL.
    run_test(K_MEM, 0, 50);                // Loads and stores with a busy dmem.
    run_test(0, 40, 40);                   // ALU under both busy levels.
    run_test(K_MEM, 40, 40);
    run_test(K_ILLEGAL | K_MEM, 25, 25);   // Trap path.
    for (int n = 0; n < 6; n++) begin
      run_test(K_BRANCH | K_MEM, 30, 30);  // Mixed programs.
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rv32_pkg.sv
register_file.sv
fetch_stage.sv
hazard_unit.sv
execute_stage.sv
two_stage_core.sv
core_tb.sv

//--- Makefile
# Verilator build and run for the two-stage core testbench.

VERILATOR ?= verilator
TOP       ?= core_tb
RTL_TOP   ?= two_stage_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation did not finish"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) \
		rv32_pkg.sv register_file.sv fetch_stage.sv hazard_unit.sv \
		execute_stage.sv two_stage_core.sv
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
